//--- mips_cpu_bus.f
src/mips_pkg.sv
src/alu.sv
src/byte_lanes.sv
src/bus_sequencer.sv
src/program_counter.sv
src/register_file.sv
src/mips_cpu_bus.sv
testbench/mips_cpu_bus_tb.sv

//--- Makefile
# Verilator build and run for the bus-mastering MIPS core
VERILATOR ?= verilator
TOP       ?= mips_cpu_bus_tb
FILELIST  ?= mips_cpu_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/mips_cpu_bus_tb.sv
////////////////////////////////////////
// random forward-only program with data in 0x100..0x1ff
// memory inserts 0..3 wait cycles per transfer
////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu_bus_tb;

	localparam logic [31:0] reset_vector = 32'hBFC00000;
	localparam int prog_len = 60;
	localparam int max_wait = 3;
	localparam int timeout_cycles = prog_len * (4 + 2 * max_wait) + 200;

	// MIPS32 encodings
	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_j = 6'h02;
	localparam logic [5:0] opc_beq = 6'h04;
	localparam logic [5:0] opc_bne = 6'h05;
	localparam logic [5:0] opc_addiu = 6'h09;
	localparam logic [5:0] opc_ori = 6'h0d;
	localparam logic [5:0] opc_lui = 6'h0f;
	localparam logic [5:0] opc_lb = 6'h20;
	localparam logic [5:0] opc_lw = 6'h23;
	localparam logic [5:0] opc_lbu = 6'h24;
	localparam logic [5:0] opc_sb = 6'h28;
	localparam logic [5:0] opc_sw = 6'h2b;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  be;
		logic [31:0] data;
	} store_t;

	logic        clk;
	logic        reset;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] address;
	logic        write;
	logic        read;
	logic        waitrequest;
	logic [31:0] writedata;
	logic [3:0]  byteenable;
	logic [31:0] readdata;

	integer      seed;
	logic [31:0] prog [prog_len];
	logic [31:0] bus_mem [bit [31:0]];
	logic [31:0] model_mem [bit [31:0]];
	logic [31:0] exp_fetch [$];
	store_t      exp_store [$];
	logic [31:0] model_v0;
	logic [31:0] exp_addr;
	store_t      exp_st;
	logic [31:0] wmask;

	int cycle_count = 0;
	int err_reset = 0;
	int err_bus = 0;
	int err_fetch = 0;
	int err_store = 0;
	int err_v0 = 0;
	int err_halt = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int bus_after_halt = 0;
	int wait_left = 0;
	bit in_xfer = 1'b0;
	bit prev_reset = 1'b0;
	bit first_read_seen = 1'b0;
	bit halted_seen = 1'b0;
	bit held = 1'b0;
	bit held_read = 1'b0;
	bit held_write = 1'b0;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic [3:0]  held_be;

	mips_cpu_bus #(.RESET_VECTOR(reset_vector)) dut (
		.clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
		.address(address), .write(write), .read(read), .waitrequest(waitrequest),
		.writedata(writedata), .byteenable(byteenable), .readdata(readdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// content of unwritten words mixes every address bit
	function automatic logic [31:0] fill_pattern(logic [31:0] addr);
		return {addr[7:0], addr[31:8]} ^ 32'h6b1dc35a;
	endfunction

	function automatic logic [31:0] bus_read(logic [31:0] addr);
		if (bus_mem.exists(addr))
			return bus_mem[addr];
		return fill_pattern(addr);
	endfunction

	function automatic logic [31:0] model_read(logic [31:0] addr);
		if (model_mem.exists(addr))
			return model_mem[addr];
		return fill_pattern(addr);
	endfunction

	function automatic logic [31:0] lane_mask(logic [3:0] be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	function automatic logic [31:0] r_type(int rs, int rt, int rd, logic [5:0] funct);
		return {opc_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_type(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] j_type(int target_index);
		logic [31:0] a;
		a = reset_vector + 32'(4 * target_index);
		return {opc_j, a[27:2]};
	endfunction

	function automatic logic [5:0] alu_funct(int k);
		case (k)
			0: return 6'h21;
			1: return 6'h23;
			2: return 6'h24;
			3: return 6'h25;
			4: return 6'h26;
			default: return 6'h2a;
		endcase
	endfunction

	// $2 picked more often so v0 keeps changing
	function automatic int dest_reg();
		int r;
		r = rand_below(9);
		return (r >= 7) ? 2 : r + 1;
	endfunction

	function automatic logic [15:0] data_imm(bit word_access);
		int off;
		off = word_access ? 4 * rand_below(64) : rand_below(256);
		return 16'h0100 + 16'(off);
	endfunction

	task automatic build_program();
		int jr_slot;
		int jr_target;
		int kind;
		int ra;
		int rb;
		int rd;
		int tgt;
		int limit;
		logic [31:0] jr_addr;
		jr_slot = 30 + rand_below(15);
		jr_target = jr_slot + 1 + rand_below(8);
		jr_addr = reset_vector + 32'(4 * jr_target);
		// $25 only ever holds the forward JR target
		prog[0] = i_type(opc_lui, 0, 25, jr_addr[31:16]);
		prog[1] = i_type(opc_ori, 25, 25, jr_addr[15:0]);
		for (int i = 2; i < 54; i++) begin
			kind = rand_below(16);
			ra = rand_below(8);
			rb = rand_below(8);
			rd = dest_reg();
			// no branch skips the JR or the fixed tail
			limit = (i < jr_slot) ? jr_slot : 54;
			tgt = i + 1 + rand_below(4);
			if (tgt > limit)
				tgt = limit;
			if (i == jr_slot)
				prog[i] = r_type(25, 0, 0, 6'h08);
			else begin
				case (kind)
					0, 1, 2, 3, 4: prog[i] = r_type(ra, rb, rd, alu_funct(rand_below(6)));
					5: prog[i] = i_type(opc_addiu, ra, rd, 16'(rand_below(65536)));
					6: prog[i] = i_type(opc_ori, ra, rd, 16'(rand_below(65536)));
					7: prog[i] = i_type(opc_lui, 0, rd, 16'(rand_below(65536)));
					8: prog[i] = i_type(opc_lb, 0, rd, data_imm(1'b0));
					9: prog[i] = i_type(opc_lbu, 0, rd, data_imm(1'b0));
					10: prog[i] = i_type(opc_lw, 0, rd, data_imm(1'b1));
					11: prog[i] = i_type(opc_sb, 0, rb, data_imm(1'b0));
					12: prog[i] = i_type(opc_sw, 0, rb, data_imm(1'b1));
					13: prog[i] = i_type(opc_beq, ra, rb, 16'(tgt - i - 1));
					14: prog[i] = i_type(opc_bne, ra, rb, 16'(tgt - i - 1));
					default: prog[i] = j_type(tgt);
				endcase
			end
		end
		// v0 = (lb + lbu) ^ lw
		prog[54] = i_type(opc_lw, 0, 4, data_imm(1'b1));
		prog[55] = i_type(opc_lbu, 0, 3, data_imm(1'b0));
		prog[56] = i_type(opc_lb, 0, 2, data_imm(1'b0));
		prog[57] = r_type(2, 3, 2, 6'h21);
		prog[58] = r_type(2, 4, 2, 6'h26);
		prog[59] = r_type(0, 0, 0, 6'h08);
		for (int i = 0; i < prog_len; i++) begin
			bus_mem[reset_vector + 32'(4 * i)] = prog[i];
			model_mem[reset_vector + 32'(4 * i)] = prog[i];
		end
	endtask

	// one instruction per step and branches act on the next fetch
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] pc4;
		logic [31:0] w;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] ea;
		logic [31:0] word;
		logic [31:0] val;
		logic [31:0] m;
		logic [15:0] imm;
		logic [4:0]  dst;
		bit          has_wr;
		bit          done;
		int          steps;
		store_t      st;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		pc = reset_vector;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			exp_fetch.push_back(pc);
			w = model_read(pc);
			imm = w[15:0];
			rs_v = regs[w[25:21]];
			rt_v = regs[w[20:16]];
			pc4 = pc + 32'd4;
			pc = pc4;
			ea = rs_v + {{16{imm[15]}}, imm};
			word = model_read({ea[31:2], 2'b00}) >> {ea[1:0], 3'b000};
			has_wr = 1'b1;
			dst = w[20:16];
			val = '0;
			case (w[31:26])
				opc_special: begin
					dst = w[15:11];
					case (w[5:0])
						6'h21: val = rs_v + rt_v;
						6'h23: val = rs_v - rt_v;
						6'h24: val = rs_v & rt_v;
						6'h25: val = rs_v | rt_v;
						6'h26: val = rs_v ^ rt_v;
						6'h2a: val = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
						6'h08: begin
							has_wr = 1'b0;
							pc = rs_v;
							done = (rs_v == '0);
						end
						default: has_wr = 1'b0;
					endcase
				end
				opc_addiu: val = rs_v + {{16{imm[15]}}, imm};
				opc_ori: val = rs_v | {16'h0000, imm};
				opc_lui: val = {imm, 16'h0000};
				opc_lb: val = {{24{word[7]}}, word[7:0]};
				opc_lbu: val = {24'h000000, word[7:0]};
				opc_lw: val = model_read({ea[31:2], 2'b00});
				default: begin
					has_wr = 1'b0;
					if (w[31:26] == opc_j)
						pc = {pc4[31:28], w[25:0], 2'b00};
					else if ((w[31:26] == opc_beq) && (rs_v == rt_v))
						pc = pc4 + {{14{imm[15]}}, imm, 2'b00};
					else if ((w[31:26] == opc_bne) && (rs_v != rt_v))
						pc = pc4 + {{14{imm[15]}}, imm, 2'b00};
					else if ((w[31:26] == opc_sb) || (w[31:26] == opc_sw)) begin
						st.addr = {ea[31:2], 2'b00};
						st.be = (w[31:26] == opc_sb) ? (4'b0001 << ea[1:0]) : 4'b1111;
						st.data = (w[31:26] == opc_sb) ? {4{rt_v[7:0]}} : rt_v;
						exp_store.push_back(st);
						m = lane_mask(st.be);
						model_mem[st.addr] = (model_read(st.addr) & ~m) | (st.data & m);
					end
				end
			endcase
			if (has_wr && (dst != 5'd0))
				regs[dst] = val;
			steps++;
		end
		model_v0 = regs[2];
	endtask

	task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
		$display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
	endtask

	task automatic report_test(string name, int errs);
		if (errs == 0) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: %0d check(s) failed", name, errs);
		end
	endtask

	// slave draws its wait count when a level first rises
	always @(posedge clk) begin
		#2;
		if (read || write) begin
			if (!in_xfer) begin
				in_xfer = 1'b1;
				wait_left = rand_below(max_wait + 1);
			end else if (wait_left > 0) begin
				wait_left = wait_left - 1;
			end
			waitrequest = (wait_left != 0);
			if (wait_left == 0) begin
				in_xfer = 1'b0;
				if (read)
					readdata = bus_read(address);
				else
					bus_mem[address] = (bus_read(address) & ~lane_mask(byteenable)) |
						(writedata & lane_mask(byteenable));
			end
		end else begin
			in_xfer = 1'b0;
			waitrequest = 1'b0;
		end
	end

	// bus monitor samples at the falling edge
	always @(negedge clk) begin
		if (reset || prev_reset) begin
			if (read || write || !active) begin
				err_reset++;
				$display("reset_state: bus level raised or active low near reset at %0t", $time);
			end
		end
		prev_reset = reset;
		if (read && write) begin
			err_bus++;
			$display("bus_rules: read and write high together at %0t", $time);
		end
		if (held && ((read !== held_read) || (write !== held_write))) begin
			err_bus++;
			$display("bus_rules: read or write level changed while waitrequest was high at %0t",
				$time);
		end
		if (held && (read || write)) begin
			if (address !== held_addr) begin
				err_bus++;
				report_mismatch("bus_rules address", held_addr, address);
			end
			if (byteenable !== held_be) begin
				err_bus++;
				report_mismatch("bus_rules byteenable", 32'(held_be), 32'(byteenable));
			end
			if (write && (writedata !== held_wdata)) begin
				err_bus++;
				report_mismatch("bus_rules writedata", held_wdata, writedata);
			end
		end
		held = (read || write) && waitrequest;
		held_read = read;
		held_write = write;
		held_addr = address;
		held_be = byteenable;
		held_wdata = writedata;
		if (read && !waitrequest) begin
			if (!first_read_seen) begin
				first_read_seen = 1'b1;
				if (address !== reset_vector) begin
					err_reset++;
					report_mismatch("reset_state first read", reset_vector, address);
				end
			end
			// program space sits above the data window
			if (address >= reset_vector) begin
				if (exp_fetch.size() == 0) begin
					err_fetch++;
					$display("fetch_order: fetch from %h after the model had halted", address);
				end else begin
					exp_addr = exp_fetch.pop_front();
					if (address !== exp_addr) begin
						err_fetch++;
						report_mismatch("fetch_order address", exp_addr, address);
					end
				end
			end
		end
		if (write && !waitrequest) begin
			if (exp_store.size() == 0) begin
				err_store++;
				$display("store_stream: write to %h that the model never made", address);
			end else begin
				exp_st = exp_store.pop_front();
				wmask = lane_mask(exp_st.be);
				if (address !== exp_st.addr) begin
					err_store++;
					report_mismatch("store_stream address", exp_st.addr, address);
				end
				if (byteenable !== exp_st.be) begin
					err_store++;
					report_mismatch("store_stream byteenable", 32'(exp_st.be), 32'(byteenable));
				end
				if ((writedata & wmask) !== (exp_st.data & wmask)) begin
					err_store++;
					report_mismatch("store_stream writedata", exp_st.data & wmask, writedata & wmask);
				end
			end
		end
		if (halted_seen && (read || write))
			bus_after_halt++;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: no halt within %0d cycles", timeout_cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		waitrequest = 1'b0;
		readdata = '0;
		seed = 76;
		build_program();
		run_model();
		repeat (16) @(posedge clk);
		#2 reset = 1'b0;
		while (active)
			@(negedge clk);
		halted_seen = 1'b1;
		if (exp_fetch.size() != 0) begin
			err_halt++;
			$display("halt: active fell with %0d fetches still expected", exp_fetch.size());
		end
		repeat (20) @(posedge clk);
		if (active || (bus_after_halt != 0)) begin
			err_halt++;
			$display("halt: bus activity or active high after the final JR");
		end
		if (exp_store.size() != 0) begin
			err_store++;
			$display("store_stream: %0d expected writes never appeared", exp_store.size());
		end
		if (register_v0 !== model_v0) begin
			err_v0++;
			report_mismatch("load_and_alu register_v0", model_v0, register_v0);
		end
		report_test("reset_state", err_reset);
		report_test("bus_rules", err_bus);
		report_test("fetch_order", err_fetch);
		report_test("store_stream", err_store);
		report_test("load_and_alu", err_v0);
		report_test("halt", err_halt);
		$display("tests passed %0d, failed %0d, cycles %0d", tests_passed, tests_failed,
			cycle_count);
		if (tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src/mips_cpu_bus.sv
////////////////////////////////////////
// one instruction at a time, no delay slot
// shared Avalon bus, word aligned address out
////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu_bus #(
	parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
	input  logic                             clk,
	input  logic                             reset,
	output logic                             active,
	output logic [mips_pkg::word_width-1:0]  register_v0,
	output logic [mips_pkg::word_width-1:0]  address,
	output logic                             write,
	output logic                             read,
	input  logic                             waitrequest,
	output logic [mips_pkg::word_width-1:0]  writedata,
	output logic [3:0]                       byteenable,
	input  logic [mips_pkg::word_width-1:0]  readdata
);
	import mips_pkg::*;

	instr_fields_t             instr;
	instr_imm_t                instr_imm;
	ctrl_t                     ctrl;
	logic                      address_sel;
	logic                      pc_update;
	logic                      reg_write_en;
	logic                      data_load;
	logic                      branch_taken;
	logic                      operands_equal;
	logic [word_width-1:0]     pc;
	logic [word_width-1:0]     rs_data;
	logic [word_width-1:0]     rt_data;
	logic [word_width-1:0]     alu_result;
	logic [word_width-1:0]     load_result;
	logic [word_width-1:0]     write_data;
	logic [reg_addr_width-1:0] write_addr;

	// same word seen through the immediate/target layout
	assign instr_imm = instr;

	// data phase uses the alu address, lane picked by byteenable
	assign address = address_sel ? {alu_result[word_width-1:2], 2'b00} : pc;

	// register write port muxes
	assign write_addr = ctrl.dest_is_rd ? instr.rd : instr.rt;
	assign write_data = ctrl.mem_to_reg ? load_result : alu_result;

	bus_sequencer u_sequencer (
		.clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
		.operands_equal(operands_equal), .pc(pc), .rs_data(rs_data),
		.instr(instr), .ctrl(ctrl), .read(read), .write(write),
		.address_sel(address_sel), .pc_update(pc_update), .reg_write_en(reg_write_en),
		.data_load(data_load), .branch_taken(branch_taken), .active(active)
	);

	program_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
		.clk(clk), .reset(reset), .pc_update(pc_update), .pc_sel(ctrl.pc_sel),
		.branch_taken(branch_taken), .instr(instr_imm), .rs_data(rs_data), .pc(pc)
	);

	register_file u_regs (
		.clk(clk), .reset(reset), .write_en(reg_write_en), .write_addr(write_addr),
		.write_data(write_data), .rs_addr(instr.rs), .rt_addr(instr.rt),
		.rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
	);

	alu u_alu (
		.clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr_imm), .rs_data(rs_data),
		.rt_data(rt_data), .alu_result(alu_result), .operands_equal(operands_equal)
	);

	byte_lanes u_lanes (
		.clk(clk), .reset(reset), .data_load(data_load), .ctrl(ctrl),
		.byte_offset(alu_result[1:0]), .rt_data(rt_data), .readdata(readdata),
		.byteenable(byteenable), .writedata(writedata), .load_result(load_result)
	);

endmodule

//--- src/register_file.sv
////////////////////////////////////////
// async read, one write port, $0 reads zero
////////////////////////////////////////
`timescale 1ns/1ps

module register_file (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                write_en,
	input  logic [mips_pkg::reg_addr_width-1:0] write_addr,
	input  logic [mips_pkg::word_width-1:0]     write_data,
	input  logic [mips_pkg::reg_addr_width-1:0] rs_addr,
	input  logic [mips_pkg::reg_addr_width-1:0] rt_addr,
	output logic [mips_pkg::word_width-1:0]     rs_data,
	output logic [mips_pkg::word_width-1:0]     rt_data,
	output logic [mips_pkg::word_width-1:0]     register_v0
);
	import mips_pkg::*;

	logic [word_width-1:0] regs [2**reg_addr_width];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_addr_width; i++)
				regs[i] <= '0;
		end else if (write_en && (write_addr != '0)) begin
			// $0 never written so stays zero
			regs[write_addr] <= write_data;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// v0 straight from the array
	assign register_v0 = regs[2];

endmodule

//--- src/program_counter.sv
////////////////////////////////////////
// next pc applied only in writeback
////////////////////////////////////////
`timescale 1ns/1ps

module program_counter #(
	parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            pc_update,
	input  mips_pkg::pc_sel_t               pc_sel,
	input  logic                            branch_taken,
	input  mips_pkg::instr_imm_t            instr,
	input  logic [mips_pkg::word_width-1:0] rs_data,
	output logic [mips_pkg::word_width-1:0] pc
);
	import mips_pkg::*;

	logic [word_width-1:0] pc_plus4;
	logic [word_width-1:0] branch_target;
	logic [word_width-1:0] jump_target;
	logic [word_width-1:0] pc_next;

	assign pc_plus4 = pc + word_width'(4);
	// word offset relative to pc+4
	assign branch_target = pc_plus4 + {{14{instr.imm[15]}}, instr.imm, 2'b00};
	// region bits kept from pc+4
	assign jump_target = {pc_plus4[31:28], instr.target_hi, instr.imm, 2'b00};

	always_comb begin
		case (pc_sel)
			pc_branch: pc_next = branch_taken ? branch_target : pc_plus4;
			pc_jump:   pc_next = jump_target;
			pc_reg:    pc_next = rs_data;
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= RESET_VECTOR;
		else if (pc_update)
			pc <= pc_next;
	end

endmodule

//--- src/bus_sequencer.sv
////////////////////////////////////////
// read/write held until waitrequest falls
// ctrl is all zero outside execute..writeback
////////////////////////////////////////
`timescale 1ns/1ps

module bus_sequencer (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            waitrequest,
	input  logic [mips_pkg::word_width-1:0] readdata,
	input  logic                            operands_equal,
	input  logic [mips_pkg::word_width-1:0] pc,
	input  logic [mips_pkg::word_width-1:0] rs_data,
	output mips_pkg::instr_fields_t         instr,
	output mips_pkg::ctrl_t                 ctrl,
	output logic                            read,
	output logic                            write,
	output logic                            address_sel,
	output logic                            pc_update,
	output logic                            reg_write_en,
	output logic                            data_load,
	output logic                            branch_taken,
	output logic                            active
);
	import mips_pkg::*;

	seq_state_t            state;
	seq_state_t            state_next;
	logic                  instr_load;
	logic                  decoding;
	logic                  is_store;
	logic                  halt_now;
	logic [word_width-1:0] pc_plus4;

	// instruction register, loaded as the fetch completes
	assign instr_load = (state == st_fetch) && !waitrequest;
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			instr <= '0;
		else if (instr_load)
			instr <= readdata;
	end

	// only decode while the instruction register is valid
	assign decoding = (state == st_execute) || (state == st_memory) ||
		(state == st_writeback);

	always_comb begin
		ctrl = '0;
		is_store = 1'b0;
		if (decoding) begin
			case (opcode_t'(instr.opcode))
				op_special: begin
					ctrl.reg_write = 1'b1;
					ctrl.dest_is_rd = 1'b1;
					case (funct_t'(instr.funct))
						fn_addu: ctrl.alu_op = alu_add;
						fn_subu: ctrl.alu_op = alu_sub;
						fn_and:  ctrl.alu_op = alu_and;
						fn_or:   ctrl.alu_op = alu_or;
						fn_xor:  ctrl.alu_op = alu_xor;
						fn_slt:  ctrl.alu_op = alu_slt;
						fn_jr: begin
							ctrl.reg_write = 1'b0;
							ctrl.pc_sel = pc_reg;
						end
						// unknown funct is a plain pc+4
						default: ctrl.reg_write = 1'b0;
					endcase
				end
				op_j: ctrl.pc_sel = pc_jump;
				op_beq: begin
					ctrl.pc_sel = pc_branch;
					ctrl.branch_if_equal = 1'b1;
				end
				op_bne: ctrl.pc_sel = pc_branch;
				op_addiu: begin
					ctrl.use_imm = 1'b1;
					ctrl.reg_write = 1'b1;
				end
				op_ori: begin
					ctrl.alu_op = alu_or;
					ctrl.use_imm = 1'b1;
					ctrl.zero_extend = 1'b1;
					ctrl.reg_write = 1'b1;
				end
				op_lui: begin
					ctrl.alu_op = alu_lui;
					ctrl.use_imm = 1'b1;
					ctrl.reg_write = 1'b1;
				end
				op_lb, op_lbu, op_lw: begin
					// address = rs + sext(imm)
					ctrl.use_imm = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.mem_to_reg = 1'b1;
					ctrl.load_byte = (opcode_t'(instr.opcode) != op_lw);
					ctrl.load_unsigned = (opcode_t'(instr.opcode) == op_lbu);
				end
				op_sb, op_sw: begin
					ctrl.use_imm = 1'b1;
					ctrl.store_byte = (opcode_t'(instr.opcode) == op_sb);
					is_store = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign branch_taken = ctrl.branch_if_equal ? operands_equal : !operands_equal;

	// program ends on a jump to address 0
	assign pc_plus4 = pc + word_width'(4);
	assign halt_now = ((ctrl.pc_sel == pc_reg) && (rs_data == '0)) ||
		((ctrl.pc_sel == pc_jump) && (pc_plus4[31:28] == 4'h0) &&
		({instr.rs, instr.rt, instr.rd, instr.shamt, instr.funct} == '0));

	always_comb begin
		state_next = state;
		case (state)
			st_reset: state_next = st_fetch;
			st_fetch: if (!waitrequest) state_next = st_execute;
			st_execute: begin
				if (ctrl.mem_to_reg || is_store)
					state_next = st_memory;
				else
					state_next = st_writeback;
			end
			st_memory: if (!waitrequest) state_next = st_writeback;
			st_writeback: state_next = halt_now ? st_halted : st_fetch;
			st_halted: state_next = st_halted;
			default: state_next = st_reset;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= st_reset;
		else
			state <= state_next;
	end

	// bus levels and datapath enables
	assign read = (state == st_fetch) || ((state == st_memory) && ctrl.mem_to_reg);
	assign write = (state == st_memory) && is_store;
	assign address_sel = (state == st_memory);
	assign data_load = (state == st_memory) && ctrl.mem_to_reg && !waitrequest;
	assign pc_update = (state == st_writeback);
	assign reg_write_en = (state == st_writeback) && ctrl.reg_write;
	assign active = (state != st_halted);

endmodule

//--- src/byte_lanes.sv
////////////////////////////////////////
// byteenable active high for reads and writes
// little endian lanes, byte 0 on bits 7:0
////////////////////////////////////////
`timescale 1ns/1ps

module byte_lanes (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            data_load,
	input  mips_pkg::ctrl_t                 ctrl,
	input  logic [1:0]                      byte_offset,
	input  logic [mips_pkg::word_width-1:0] rt_data,
	input  logic [mips_pkg::word_width-1:0] readdata,
	output logic [3:0]                      byteenable,
	output logic [mips_pkg::word_width-1:0] writedata,
	output logic [mips_pkg::word_width-1:0] load_result
);
	import mips_pkg::*;

	logic [word_width-1:0] load_data;
	logic [7:0]            load_byte_sel;

	// one lane for byte ops, all four otherwise
	assign byteenable = (ctrl.load_byte || ctrl.store_byte) ? (4'b0001 << byte_offset) :
		4'b1111;

	// SB puts the byte on every lane, slave takes the enabled one
	assign writedata = ctrl.store_byte ? {4{rt_data[7:0]}} : rt_data;

	// load data captured as the memory read completes
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			load_data <= '0;
		else if (data_load)
			load_data <= readdata;
	end

	always_comb begin
		case (byte_offset)
			2'd0: load_byte_sel = load_data[7:0];
			2'd1: load_byte_sel = load_data[15:8];
			2'd2: load_byte_sel = load_data[23:16];
			default: load_byte_sel = load_data[31:24];
		endcase
	end

	// LB signs, LBU zero fills, LW passes the word
	always_comb begin
		if (!ctrl.load_byte)
			load_result = load_data;
		else if (ctrl.load_unsigned)
			load_result = {24'h000000, load_byte_sel};
		else
			load_result = {{24{load_byte_sel[7]}}, load_byte_sel};
	end

endmodule

//--- src/alu.sv
////////////////////////////////////////
// result register samples every cycle
// operands hold still from execute on
////////////////////////////////////////
`timescale 1ns/1ps

module alu (
	input  logic                            clk,
	input  logic                            reset,
	input  mips_pkg::ctrl_t                 ctrl,
	input  mips_pkg::instr_imm_t            instr,
	input  logic [mips_pkg::word_width-1:0] rs_data,
	input  logic [mips_pkg::word_width-1:0] rt_data,
	output logic [mips_pkg::word_width-1:0] alu_result,
	output logic                            operands_equal
);
	import mips_pkg::*;

	logic [word_width-1:0] imm_ext;
	logic [word_width-1:0] operand_b;
	logic [word_width-1:0] result_next;
	logic                  less_than;

	// ORI zero extends, everything else signs
	assign imm_ext = ctrl.zero_extend ? {16'h0000, instr.imm} :
		{{16{instr.imm[15]}}, instr.imm};
	assign operand_b = ctrl.use_imm ? imm_ext : rt_data;
	assign less_than = $signed(rs_data) < $signed(operand_b);

	always_comb begin
		case (ctrl.alu_op)
			alu_add: result_next = rs_data + operand_b;
			alu_sub: result_next = rs_data - operand_b;
			alu_and: result_next = rs_data & operand_b;
			alu_or:  result_next = rs_data | operand_b;
			alu_xor: result_next = rs_data ^ operand_b;
			alu_slt: result_next = {{(word_width-1){1'b0}}, less_than};
			alu_lui: result_next = {instr.imm, 16'h0000};
			default: result_next = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			alu_result <= '0;
		else
			alu_result <= result_next;
	end

	// branch compare, always rs against rt
	assign operands_equal = (rs_data == rt_data);

endmodule

//--- src/mips_pkg.sv
////////////////////////////////////////
// shared types for the bus-mastering MIPS subset core
// enum encodings follow the MIPS32 opcode and funct fields
////////////////////////////////////////
package mips_pkg;

	localparam int word_width     = 32;
	localparam int reg_addr_width = 5;

	// primary opcode, only the supported subset
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_sb      = 6'h28,
		op_sw      = 6'h2b
	} opcode_t;

	// funct field of op_special
	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_lui
	} alu_op_t;

	typedef enum logic [2:0] {
		st_reset,
		st_fetch,
		st_execute,
		st_memory,
		st_writeback,
		st_halted
	} seq_state_t;

	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_jump,
		pc_reg
	} pc_sel_t;

	// R-type view of the instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_fields_t;

	// I/J-type view, jump target is {target_hi, imm}
	typedef struct packed {
		logic [5:0]  opcode;
		logic [9:0]  target_hi;
		logic [15:0] imm;
	} instr_imm_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;
		logic    zero_extend;
		logic    reg_write;
		logic    dest_is_rd;
		logic    mem_to_reg;
		logic    load_byte;
		logic    load_unsigned;
		logic    store_byte;
		logic    branch_if_equal;
		pc_sel_t pc_sel;
	} ctrl_t;

endpackage
